// ==== logic/dbc_defs.svh ====
/*
 * Daughterboard control address map
 * Settings bus addresses, register offsets and readback selects
 */
`ifndef DBC_DEFS_SVH
`define DBC_DEFS_SVH

// Settings bus register addresses
`define SR_MISC_OUTS 8'h10
`define SR_SYNC      8'h11
`define SR_SPI       8'h18
`define SR_LEDS      8'h20
`define SR_FP_GPIO   8'h28
`define SR_DB_GPIO   8'h30

// Offsets within a GPIO bank
`define GPIO_IDLE 8'd0
`define GPIO_RX   8'd1
`define GPIO_TX   8'd2
`define GPIO_FDX  8'd3
`define GPIO_DDR  8'd4

// Offsets within the SPI block
`define SPI_DIV  8'd0
`define SPI_CTRL 8'd1
`define SPI_DATA 8'd2

// Readback select values
`define RB_MISC_IO 8'd0
`define RB_SPI     8'd1
`define RB_LEDS    8'd2
`define RB_DB_GPIO 8'd3
`define RB_FP_GPIO 8'd4

// Returned for any readback address nobody owns
`define RB_DEFAULT 64'h0BAD_C0DE_0BAD_C0DE

`endif

// ==== logic/dbc_pkg.sv ====
/*
 * Daughterboard control types
 * Bus widths, GPIO words and the SPI master state encoding
 */
package dbc_pkg;

  // Settings bus
  typedef logic [7:0]  sr_addr_t;
  typedef logic [31:0] sr_data_t;

  // Readback word
  typedef logic [63:0] rb_data_t;

  // One GPIO bank
  typedef logic [31:0] gpio_word_t;

  // SPI chip selects, active low
  typedef logic [7:0]  spi_sen_t;

  // SPI master sequence
  typedef enum logic [1:0] {
    SPI_IDLE,
    SPI_LEAD,
    SPI_SHIFT,
    SPI_DONE
  } spi_state_t;

endpackage

// ==== logic/gpio_atr.sv ====
/*
 * Automatic transmit/receive GPIO bank
 * Drives one of four output patterns picked by run_rx/run_tx and
 * returns a per-bit mix of pins and outputs for software readback
 */
`timescale 1ns/1ps
`include "dbc_defs.svh"

module gpio_atr #(
  parameter dbc_pkg::sr_addr_t BASE = 8'h00
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                set_stb,
  input  dbc_pkg::sr_addr_t   set_addr,
  input  dbc_pkg::sr_data_t   set_data,
  input  logic                run_rx,
  input  logic                run_tx,
  input  dbc_pkg::gpio_word_t gpio_in,
  output dbc_pkg::gpio_word_t gpio_out,
  output dbc_pkg::gpio_word_t gpio_ddr,
  output dbc_pkg::gpio_word_t sw_rb
);

  dbc_pkg::gpio_word_t idle_reg;
  dbc_pkg::gpio_word_t rx_reg;
  dbc_pkg::gpio_word_t tx_reg;
  dbc_pkg::gpio_word_t fdx_reg;
  dbc_pkg::gpio_word_t next_out;

  logic wr_idle;
  logic wr_rx;
  logic wr_tx;
  logic wr_fdx;
  logic wr_ddr;

  // Address decode for this bank only
  assign wr_idle = set_stb && (set_addr == BASE + `GPIO_IDLE);
  assign wr_rx   = set_stb && (set_addr == BASE + `GPIO_RX);
  assign wr_tx   = set_stb && (set_addr == BASE + `GPIO_TX);
  assign wr_fdx  = set_stb && (set_addr == BASE + `GPIO_FDX);
  assign wr_ddr  = set_stb && (set_addr == BASE + `GPIO_DDR);

  // Pattern and direction registers
  always_ff @(posedge clk) begin
    if (reset) begin
      idle_reg <= '0;
      rx_reg   <= '0;
      tx_reg   <= '0;
      fdx_reg  <= '0;
      gpio_ddr <= '1;
    end else begin
      if (wr_idle) begin
        idle_reg <= set_data;
      end
      if (wr_rx) begin
        rx_reg <= set_data;
      end
      if (wr_tx) begin
        tx_reg <= set_data;
      end
      if (wr_fdx) begin
        fdx_reg <= set_data;
      end
      if (wr_ddr) begin
        gpio_ddr <= set_data;
      end
    end
  end

  // Pattern select from the current radio state
  always_comb begin
    case ({run_tx, run_rx})
      2'b01:   next_out = rx_reg;
      2'b10:   next_out = tx_reg;
      2'b11:   next_out = fdx_reg;
      default: next_out = idle_reg;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      gpio_out <= '0;
    end else begin
      gpio_out <= next_out;
    end
  end

  // Outputs read back what we drive, inputs read back the pin
  always_ff @(posedge clk) begin
    sw_rb <= (gpio_out & gpio_ddr) | (gpio_in & ~gpio_ddr);
  end

endmodule

// ==== logic/spi_master.sv ====
/*
 * Mode-0 SPI master on the settings bus
 * Shifts up to 32 bits MSB first with a programmable sclk divider
 * and returns the received bits right-aligned
 */
`timescale 1ns/1ps
`include "dbc_defs.svh"

module spi_master #(
  parameter dbc_pkg::sr_addr_t BASE = 8'h00
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              set_stb,
  input  dbc_pkg::sr_addr_t set_addr,
  input  dbc_pkg::sr_data_t set_data,
  output dbc_pkg::sr_data_t readback,
  output logic              readback_stb,
  output logic              ready,
  output dbc_pkg::spi_sen_t sen,
  output logic              sclk,
  output logic              mosi,
  input  logic              miso
);

  dbc_pkg::spi_state_t state;
  dbc_pkg::sr_data_t   tx_data;
  dbc_pkg::sr_data_t   shift_out;
  dbc_pkg::sr_data_t   shift_in;
  logic [15:0]         divider;
  logic [15:0]         div_cnt;
  logic [5:0]          bits_left;
  logic                wr_div;
  logic                wr_ctrl;
  logic                wr_data;
  logic                half_done;

  assign wr_div  = set_stb && (set_addr == BASE + `SPI_DIV);
  assign wr_ctrl = set_stb && (set_addr == BASE + `SPI_CTRL);
  assign wr_data = set_stb && (set_addr == BASE + `SPI_DATA);

  assign ready     = (state == dbc_pkg::SPI_IDLE);
  assign half_done = (div_cnt == 16'd0);

  // Configuration writes may land at any time
  always_ff @(posedge clk) begin
    if (reset) begin
      divider <= '0;
    end else if (wr_div) begin
      divider <= set_data[15:0];
    end
  end

  always_ff @(posedge clk) begin
    if (wr_data) begin
      tx_data <= set_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state        <= dbc_pkg::SPI_IDLE;
      sen          <= 8'hFF;
      sclk         <= 1'b0;
      mosi         <= 1'b0;
      readback     <= '0;
      readback_stb <= 1'b0;
      div_cnt      <= '0;
      bits_left    <= '0;
      shift_out    <= '0;
      shift_in     <= '0;
    end else begin
      readback_stb <= 1'b0;
      case (state)
        dbc_pkg::SPI_IDLE: begin
          // Trigger only takes effect here, so busy triggers drop
          if (wr_ctrl) begin
            sen       <= ~set_data[7:0];
            mosi      <= tx_data[31];
            shift_out <= {tx_data[30:0], 1'b0};
            shift_in  <= '0;
            div_cnt   <= divider;
            // Zero count means a full 32-bit word
            bits_left <= (set_data[13:8] == 6'd0) ? 6'd32 : set_data[13:8];
            state     <= dbc_pkg::SPI_LEAD;
          end
        end

        dbc_pkg::SPI_LEAD: begin
          // Half period with sen low before the first rising edge
          if (half_done) begin
            sclk     <= 1'b1;
            shift_in <= {shift_in[30:0], miso};
            div_cnt  <= divider;
            state    <= dbc_pkg::SPI_SHIFT;
          end else begin
            div_cnt <= div_cnt - 16'd1;
          end
        end

        dbc_pkg::SPI_SHIFT: begin
          if (!half_done) begin
            div_cnt <= div_cnt - 16'd1;
          end else if (sclk) begin
            // Falling edge, present the next bit or wrap up
            sclk      <= 1'b0;
            div_cnt   <= divider;
            bits_left <= bits_left - 6'd1;
            if (bits_left == 6'd1) begin
              state <= dbc_pkg::SPI_DONE;
            end else begin
              mosi      <= shift_out[31];
              shift_out <= {shift_out[30:0], 1'b0};
            end
          end else begin
            // Rising edge, sample miso
            sclk     <= 1'b1;
            shift_in <= {shift_in[30:0], miso};
            div_cnt  <= divider;
          end
        end

        dbc_pkg::SPI_DONE: begin
          // Trailing half period before releasing the selects
          if (half_done) begin
            sen          <= 8'hFF;
            mosi         <= 1'b0;
            readback     <= shift_in;
            readback_stb <= 1'b1;
            state        <= dbc_pkg::SPI_IDLE;
          end else begin
            div_cnt <= div_cnt - 16'd1;
          end
        end

        default: begin
          state <= dbc_pkg::SPI_IDLE;
        end
      endcase
    end
  end

endmodule

// ==== logic/db_control.sv ====
/*
 * Daughterboard control top level
 * Misc outputs, sync pulse, three ATR GPIO banks, SPI master and readback
 */
`timescale 1ns/1ps
`include "dbc_defs.svh"

module db_control (
  input  logic                clk,
  input  logic                reset,
  input  logic                set_stb,
  input  dbc_pkg::sr_addr_t   set_addr,
  input  dbc_pkg::sr_data_t   set_data,
  input  dbc_pkg::sr_addr_t   rb_addr,
  output logic                rb_stb,
  output dbc_pkg::rb_data_t   rb_data,
  input  logic                run_rx,
  input  logic                run_tx,
  input  dbc_pkg::sr_data_t   misc_ins,
  output dbc_pkg::sr_data_t   misc_outs,
  output logic                sync,
  input  dbc_pkg::gpio_word_t fp_gpio_in,
  output dbc_pkg::gpio_word_t fp_gpio_out,
  output dbc_pkg::gpio_word_t fp_gpio_ddr,
  input  dbc_pkg::gpio_word_t db_gpio_in,
  output dbc_pkg::gpio_word_t db_gpio_out,
  output dbc_pkg::gpio_word_t db_gpio_ddr,
  output dbc_pkg::gpio_word_t leds,
  output dbc_pkg::spi_sen_t   sen,
  output logic                sclk,
  output logic                mosi,
  input  logic                miso
);

  dbc_pkg::gpio_word_t leds_rb;
  dbc_pkg::gpio_word_t fp_rb;
  dbc_pkg::gpio_word_t db_rb;
  dbc_pkg::sr_data_t   spi_rb;
  logic                spi_rb_stb;
  logic                spi_done;

  // Misc outputs and one-cycle sync
  always_ff @(posedge clk) begin
    if (reset) begin
      misc_outs <= '0;
      sync      <= 1'b0;
    end else begin
      if (set_stb && (set_addr == `SR_MISC_OUTS)) begin
        misc_outs <= set_data;
      end
      sync <= set_stb && (set_addr == `SR_SYNC);
    end
  end

  // Done flag survives repeated readbacks until the next trigger
  always_ff @(posedge clk) begin
    if (reset) begin
      spi_done <= 1'b0;
    end else if (set_stb && (set_addr == `SR_SPI + `SPI_CTRL)) begin
      spi_done <= 1'b0;
    end else if (spi_rb_stb) begin
      spi_done <= 1'b1;
    end
  end

  // Readback mux, valid in the same cycle as rb_addr
  always_comb begin
    rb_stb = 1'b1;
    case (rb_addr)
      `RB_MISC_IO: rb_data = {misc_ins, misc_outs};
      `RB_SPI: begin
        // Strobe follows the done latch of the last transfer
        rb_stb  = spi_done;
        rb_data = {32'd0, spi_rb};
      end
      `RB_LEDS:    rb_data = {32'd0, leds_rb};
      `RB_DB_GPIO: rb_data = {32'd0, db_rb};
      `RB_FP_GPIO: rb_data = {32'd0, fp_rb};
      default:     rb_data = `RB_DEFAULT;
    endcase
  end

  // LEDs are output only, no pins to sample
  gpio_atr #(.BASE(`SR_LEDS)) leds_atr (
    .clk(clk), .reset(reset),
    .set_stb(set_stb), .set_addr(set_addr), .set_data(set_data),
    .run_rx(run_rx), .run_tx(run_tx),
    .gpio_in('0), .gpio_out(leds), .gpio_ddr(), .sw_rb(leds_rb)
  );

  gpio_atr #(.BASE(`SR_FP_GPIO)) fp_atr (
    .clk(clk), .reset(reset),
    .set_stb(set_stb), .set_addr(set_addr), .set_data(set_data),
    .run_rx(run_rx), .run_tx(run_tx),
    .gpio_in(fp_gpio_in), .gpio_out(fp_gpio_out), .gpio_ddr(fp_gpio_ddr), .sw_rb(fp_rb)
  );

  gpio_atr #(.BASE(`SR_DB_GPIO)) db_atr (
    .clk(clk), .reset(reset),
    .set_stb(set_stb), .set_addr(set_addr), .set_data(set_data),
    .run_rx(run_rx), .run_tx(run_tx),
    .gpio_in(db_gpio_in), .gpio_out(db_gpio_out), .gpio_ddr(db_gpio_ddr), .sw_rb(db_rb)
  );

  spi_master #(.BASE(`SR_SPI)) spi (
    .clk(clk), .reset(reset),
    .set_stb(set_stb), .set_addr(set_addr), .set_data(set_data),
    .readback(spi_rb), .readback_stb(spi_rb_stb), .ready(),
    .sen(sen), .sclk(sclk), .mosi(mosi), .miso(miso)
  );

endmodule

// ==== sim/db_control_assert.sv ====
/*
 * Concurrent checks on the daughterboard control top level
 * Sync pulse width, idle sclk and readback strobe
 */
`timescale 1ns/1ps
`include "dbc_defs.svh"

module db_control_assert (
  input logic              clk,
  input logic              reset,
  input logic              sync,
  input logic              sclk,
  input dbc_pkg::spi_sen_t sen,
  input dbc_pkg::sr_addr_t rb_addr,
  input logic              rb_stb
);

  int fail_count = 0;

  // Sync is a single-cycle pulse
  sync_single: assert property (@(posedge clk) disable iff (reset) sync |=> !sync)
    else begin
      $error("sync stayed high for two cycles");
      fail_count++;
    end

  // No clock edges unless a slave is selected
  sclk_idle: assert property (@(posedge clk) disable iff (reset) (sen == 8'hFF) |-> !sclk)
    else begin
      $error("sclk high with all chip selects released");
      fail_count++;
    end

  rb_stb_fixed: assert property (@(posedge clk) disable iff (reset)
                                 (rb_addr != `RB_SPI) |-> rb_stb)
    else begin
      $error("rb_stb low at a readback address other than SPI");
      fail_count++;
    end

endmodule

bind db_control db_control_assert sva (
  .clk(clk), .reset(reset), .sync(sync), .sclk(sclk), .sen(sen),
  .rb_addr(rb_addr), .rb_stb(rb_stb)
);

// ==== sim/db_control_tb.sv ====
/*
 * Testbench for the daughterboard control block
 * Settings writes, ATR GPIO banks, readback mux and an SPI loopback
 */
`timescale 1ns/1ps
`include "dbc_defs.svh"

module db_control_tb;

  localparam int CLK_PERIOD  = 4;
  localparam int DRIVE_DELAY = 1;
  localparam int RESET_CYCLES = 5;
  localparam int SEED = 32'h9b0cac27;
  localparam int NUM_SPI  = 8;
  localparam int MAX_BITS = 32;
  localparam int MAX_DIV  = 7;
  // Worst case transfer is two half periods per bit plus lead and trail
  localparam int SPI_CYCLES = (2 * MAX_BITS + 2) * (MAX_DIV + 1) + 8;
  localparam int WATCHDOG_CYCLES = NUM_SPI * (SPI_CYCLES + 10) + 200;

  logic                clk;
  logic                reset;
  logic                set_stb;
  dbc_pkg::sr_addr_t   set_addr;
  dbc_pkg::sr_data_t   set_data;
  dbc_pkg::sr_addr_t   rb_addr;
  logic                rb_stb;
  dbc_pkg::rb_data_t   rb_data;
  logic                run_rx;
  logic                run_tx;
  dbc_pkg::sr_data_t   misc_ins;
  dbc_pkg::sr_data_t   misc_outs;
  logic                sync;
  dbc_pkg::gpio_word_t fp_gpio_in;
  dbc_pkg::gpio_word_t fp_gpio_out;
  dbc_pkg::gpio_word_t fp_gpio_ddr;
  dbc_pkg::gpio_word_t db_gpio_in;
  dbc_pkg::gpio_word_t db_gpio_out;
  dbc_pkg::gpio_word_t db_gpio_ddr;
  dbc_pkg::gpio_word_t leds;
  dbc_pkg::spi_sen_t   sen;
  logic                sclk;
  logic                mosi;

  int                  checks = 0;
  int                  errors = 0;
  int                  spi_sent = 0;
  int                  spi_seen = 0;
  dbc_pkg::spi_sen_t   spi_mask = 8'h00;
  dbc_pkg::sr_data_t   exp_q [$];

  // SPI loopback, miso follows mosi
  db_control DUT (
    .clk(clk), .reset(reset),
    .set_stb(set_stb), .set_addr(set_addr), .set_data(set_data),
    .rb_addr(rb_addr), .rb_stb(rb_stb), .rb_data(rb_data),
    .run_rx(run_rx), .run_tx(run_tx),
    .misc_ins(misc_ins), .misc_outs(misc_outs), .sync(sync),
    .fp_gpio_in(fp_gpio_in), .fp_gpio_out(fp_gpio_out), .fp_gpio_ddr(fp_gpio_ddr),
    .db_gpio_in(db_gpio_in), .db_gpio_out(db_gpio_out), .db_gpio_ddr(db_gpio_ddr),
    .leds(leds), .sen(sen), .sclk(sclk), .mosi(mosi), .miso(mosi)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Loopback returns the first n bits sent, right-aligned
  function automatic dbc_pkg::sr_data_t spi_expect(input dbc_pkg::sr_data_t data,
                                                   input int nbits);
    if (nbits >= 32) begin
      return data;
    end
    return data >> (32 - nbits);
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  task automatic sr_write(input dbc_pkg::sr_addr_t addr, input dbc_pkg::sr_data_t data);
    set_stb  = 1'b1;
    set_addr = addr;
    set_data = data;
    next_cycle();
    set_stb = 1'b0;
  endtask

  task automatic check_word(input string what, input dbc_pkg::gpio_word_t got,
                            input dbc_pkg::gpio_word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error @%0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_rb(input string what, input dbc_pkg::rb_data_t got,
                          input dbc_pkg::rb_data_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error @%0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_sen(input string what, input dbc_pkg::spi_sen_t got,
                           input dbc_pkg::spi_sen_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error @%0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error @%0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  // Compares each SPI result once the done flag shows at RB_SPI
  initial begin
    dbc_pkg::sr_data_t expected;
    forever begin
      @(negedge clk);
      if (spi_seen != spi_sent && rb_addr == `RB_SPI) begin
        if (rb_stb) begin
          expected = exp_q.pop_front();
          check_rb("SPI readback", rb_data, {32'd0, expected});
          spi_seen++;
        end else if (sclk) begin
          check_sen("sen during transfer", sen, ~spi_mask);
        end
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the test did not finish", WATCHDOG_CYCLES);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    dbc_pkg::gpio_word_t pat [3][4];
    dbc_pkg::sr_addr_t   bases [3];
    dbc_pkg::sr_data_t   word;
    dbc_pkg::sr_data_t   ins;
    dbc_pkg::gpio_word_t ddr_fp;
    dbc_pkg::gpio_word_t ddr_db;
    dbc_pkg::gpio_word_t pins_fp;
    dbc_pkg::gpio_word_t pins_db;
    logic [5:0]          nbits_field;
    logic [15:0]         div;
    int                  nbits;

    reset      = 1'b1;
    set_stb    = 1'b0;
    set_addr   = '0;
    set_data   = '0;
    rb_addr    = '0;
    run_rx     = 1'b0;
    run_tx     = 1'b0;
    misc_ins   = '0;
    fp_gpio_in = '0;
    db_gpio_in = '0;
    bases      = '{`SR_LEDS, `SR_FP_GPIO, `SR_DB_GPIO};
    void'($urandom(SEED));
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    reset = 1'b0;

    check_word("misc_outs after reset", misc_outs, '0);
    check_sen("sen after reset", sen, 8'hFF);
    check_bit("sclk after reset", sclk, 1'b0);
    rb_addr = 8'h77;
    next_cycle();
    check_rb("unknown readback", rb_data, `RB_DEFAULT);
    check_bit("unknown rb_stb", rb_stb, 1'b1);

    // Misc register and sync pulse
    rb_addr = `RB_MISC_IO;
    for (int i = 0; i < 6; i++) begin
      word     = $urandom;
      ins      = $urandom;
      misc_ins = ins;
      sr_write(`SR_MISC_OUTS, word);
      check_word("misc_outs", misc_outs, word);
      check_rb("misc readback", rb_data, {ins, word});
    end
    sr_write(`SR_SYNC, '0);
    check_bit("sync pulse", sync, 1'b1);
    next_cycle();
    check_bit("sync release", sync, 1'b0);

    // ATR patterns, idle/rx/tx/fdx sit at offsets 0 to 3
    for (int b = 0; b < 3; b++) begin
      for (int s = 0; s < 4; s++) begin
        pat[b][s] = $urandom;
        sr_write(bases[b] + `GPIO_IDLE + 8'(s), pat[b][s]);
      end
    end
    for (int s = 0; s < 4; s++) begin
      {run_tx, run_rx} = 2'(s);
      next_cycle();
      check_word("leds", leds, pat[0][s]);
      check_word("fp_gpio_out", fp_gpio_out, pat[1][s]);
      check_word("db_gpio_out", db_gpio_out, pat[2][s]);
    end

    // Direction mix, run state stays full duplex
    ddr_fp     = $urandom;
    ddr_db     = $urandom;
    pins_fp    = $urandom;
    pins_db    = $urandom;
    fp_gpio_in = pins_fp;
    db_gpio_in = pins_db;
    sr_write(`SR_FP_GPIO + `GPIO_DDR, ddr_fp);
    sr_write(`SR_DB_GPIO + `GPIO_DDR, ddr_db);
    check_word("fp_gpio_ddr", fp_gpio_ddr, ddr_fp);
    check_word("db_gpio_ddr", db_gpio_ddr, ddr_db);
    rb_addr = `RB_FP_GPIO;
    next_cycle();
    check_rb("fp readback", rb_data, {32'd0, (pat[1][3] & ddr_fp) | (pins_fp & ~ddr_fp)});
    rb_addr = `RB_DB_GPIO;
    next_cycle();
    check_rb("db readback", rb_data, {32'd0, (pat[2][3] & ddr_db) | (pins_db & ~ddr_db)});
    rb_addr = `RB_LEDS;
    next_cycle();
    check_rb("leds readback", rb_data, {32'd0, pat[0][3]});

    // SPI loopback, first transfer uses the full 32 bits
    for (int i = 0; i < NUM_SPI; i++) begin
      word        = $urandom;
      nbits_field = (i == 0) ? 6'd0 : 6'($urandom_range(1, MAX_BITS - 1));
      div         = 16'($urandom_range(0, MAX_DIV));
      spi_mask    = 8'($urandom_range(1, 255));
      nbits       = (nbits_field == 6'd0) ? MAX_BITS : int'(nbits_field);
      sr_write(`SR_SPI + `SPI_DIV, {16'd0, div});
      sr_write(`SR_SPI + `SPI_DATA, word);
      rb_addr = `RB_SPI;
      sr_write(`SR_SPI + `SPI_CTRL, {18'd0, nbits_field, spi_mask});
      check_sen("sen after trigger", sen, ~spi_mask);
      check_bit("rb_stb after trigger", rb_stb, 1'b0);
      exp_q.push_back(spi_expect(word, nbits));
      spi_sent++;
      while (spi_seen != spi_sent) begin
        next_cycle();
      end
    end

    next_cycle();
    $display("Checks: %0d, value errors: %0d, assertion failures: %0d",
             checks, errors, DUT.sva.fail_count);
    if (errors == 0 && DUT.sva.fail_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+logic
logic/dbc_pkg.sv
logic/gpio_atr.sv
logic/spi_master.sv
logic/db_control.sv
sim/db_control_assert.sv
sim/db_control_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the daughterboard control testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module db_control_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

# Raise the error limit so the testbench reaches its own summary
output=$(./obj_dir/Vdb_control_tb +verilator+error+limit+100)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "TEST RESULT: PASS"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
